//--- issue_pkg.sv
package issue_pkg;

    // queue geometry
    localparam int DEPTH = 8;
    localparam int IN_PORTS = 2;
    localparam int OUT_PORTS = 2;
    localparam int WB_CHANNELS = 3;

    // execution units per class
    localparam int ALU_NUM = 2;
    localparam int LSU_NUM = 1;
    localparam int MUL_NUM = 1;

    localparam int PHY_W = 6;
    localparam int ROB_W = 5;
    localparam int DATA_W = 32;

    // occupancy counter has to reach DEPTH itself
    localparam int CNT_W = $clog2(DEPTH + 1);

    // per-class budget and used-port counters in select
    localparam int BUDGET_W = $clog2(ALU_NUM + LSU_NUM + MUL_NUM + 1);
    localparam int PORT_W = $clog2(OUT_PORTS + 1);

    // compaction candidates: stored entries followed by dispatch ports
    localparam int MERGE_NUM = DEPTH + IN_PORTS;
    localparam int SRC_W = $clog2(MERGE_NUM);

    typedef enum logic [1:0] {
        alu = 2'd0,
        lsu = 2'd1,
        mul = 2'd2
    } op_unit_t;

    typedef struct packed {
        logic [ROB_W-1:0] rob_id;
        op_unit_t op_unit;
        logic [PHY_W-1:0] rs1_phy;
        logic src1_loaded;
        logic [DATA_W-1:0] src1_value;
        logic [PHY_W-1:0] rs2_phy;
        logic src2_loaded;
        logic [DATA_W-1:0] src2_value;
        logic [PHY_W-1:0] rd_phy;
    } iq_entry_t;

    typedef struct packed {
        logic enable;
        logic [PHY_W-1:0] phy_id;
        logic [DATA_W-1:0] value;
    } wb_channel_t;

    typedef wb_channel_t [WB_CHANNELS-1:0] wb_feedback_t;

    // a set bit means that unit takes one operation this cycle
    typedef struct packed {
        logic [ALU_NUM-1:0] alu;
        logic [LSU_NUM-1:0] lsu;
        logic [MUL_NUM-1:0] mul;
    } unit_free_t;

    // population count over a zero-extended 32-bit word
    function automatic int count_ones(input logic [31:0] bits);
        int total;
        total = 0;
        for (int b = 0; b < 32; b++) begin
            total += int'(bits[b]);
        end
        return total;
    endfunction

endpackage

//--- iq_wakeup.sv
`timescale 1ns/1ps

module iq_wakeup (
    input issue_pkg::iq_entry_t entries [0:issue_pkg::DEPTH-1],
    input issue_pkg::wb_feedback_t wb_feedback,
    output issue_pkg::iq_entry_t woken [0:issue_pkg::DEPTH-1]
);

    // one hit bit per feedback channel, per entry and source
    logic [issue_pkg::WB_CHANNELS-1:0] src1_match [0:issue_pkg::DEPTH-1];
    logic [issue_pkg::WB_CHANNELS-1:0] src2_match [0:issue_pkg::DEPTH-1];

    always_comb begin
        for (int i = 0; i < issue_pkg::DEPTH; i++) begin
            for (int c = 0; c < issue_pkg::WB_CHANNELS; c++) begin
                src1_match[i][c] = wb_feedback[c].enable
                                   && (wb_feedback[c].phy_id == entries[i].rs1_phy);
                src2_match[i][c] = wb_feedback[c].enable
                                   && (wb_feedback[c].phy_id == entries[i].rs2_phy);
            end
        end
    end

    // capture operand values; the scan runs downward so the
    // lowest-numbered matching channel is the one that sticks
    always_comb begin
        for (int i = 0; i < issue_pkg::DEPTH; i++) begin
            woken[i] = entries[i];

            if (!entries[i].src1_loaded) begin
                for (int c = issue_pkg::WB_CHANNELS - 1; c >= 0; c--) begin
                    if (src1_match[i][c]) begin
                        woken[i].src1_loaded = 1'b1;
                        woken[i].src1_value = wb_feedback[c].value;
                    end
                end
            end

            if (!entries[i].src2_loaded) begin
                for (int c = issue_pkg::WB_CHANNELS - 1; c >= 0; c--) begin
                    if (src2_match[i][c]) begin
                        woken[i].src2_loaded = 1'b1;
                        woken[i].src2_value = wb_feedback[c].value;
                    end
                end
            end
        end
    end

endmodule

//--- iq_select.sv
`timescale 1ns/1ps

module iq_select (
    input issue_pkg::iq_entry_t woken [0:issue_pkg::DEPTH-1],
    input logic [issue_pkg::CNT_W-1:0] count,
    input issue_pkg::unit_free_t unit_free,
    output logic [issue_pkg::DEPTH-1:0] issued_mask,
    output issue_pkg::iq_entry_t issue_data [0:issue_pkg::OUT_PORTS-1],
    output logic [issue_pkg::OUT_PORTS-1:0] issue_valid
);

    logic [issue_pkg::DEPTH-1:0] valid_vec;
    logic [issue_pkg::DEPTH-1:0] ready_vec;

    // state carried along the age-ordered chain
    logic [issue_pkg::BUDGET_W-1:0] alu_left;
    logic [issue_pkg::BUDGET_W-1:0] lsu_left;
    logic [issue_pkg::BUDGET_W-1:0] mul_left;
    logic [issue_pkg::PORT_W-1:0] ports_used;
    logic older_lsu;
    logic budget_ok;

    // issue port an entry lands on when it issues
    logic [issue_pkg::PORT_W-1:0] slot [0:issue_pkg::DEPTH-1];

    always_comb begin
        for (int i = 0; i < issue_pkg::DEPTH; i++) begin
            valid_vec[i] = issue_pkg::CNT_W'(i) < count;
            ready_vec[i] = woken[i].src1_loaded && woken[i].src2_loaded;
        end
    end

    always_comb begin
        alu_left = issue_pkg::BUDGET_W'(issue_pkg::count_ones(32'(unit_free.alu)));
        lsu_left = issue_pkg::BUDGET_W'(issue_pkg::count_ones(32'(unit_free.lsu)));
        mul_left = issue_pkg::BUDGET_W'(issue_pkg::count_ones(32'(unit_free.mul)));
        ports_used = '0;
        older_lsu = 1'b0;
        issued_mask = '0;

        for (int i = 0; i < issue_pkg::DEPTH; i++) begin
            slot[i] = ports_used;

            case (woken[i].op_unit)
                issue_pkg::alu: budget_ok = (alu_left != '0);
                // memory operations leave in program order
                issue_pkg::lsu: budget_ok = (lsu_left != '0) && !older_lsu;
                issue_pkg::mul: budget_ok = (mul_left != '0);
                default: budget_ok = 1'b0;
            endcase

            issued_mask[i] = valid_vec[i] && ready_vec[i] && budget_ok
                             && (ports_used < issue_pkg::PORT_W'(issue_pkg::OUT_PORTS));

            if (issued_mask[i]) begin
                ports_used = ports_used + issue_pkg::PORT_W'(1);
                case (woken[i].op_unit)
                    issue_pkg::alu: alu_left = alu_left - issue_pkg::BUDGET_W'(1);
                    issue_pkg::lsu: lsu_left = lsu_left - issue_pkg::BUDGET_W'(1);
                    issue_pkg::mul: mul_left = mul_left - issue_pkg::BUDGET_W'(1);
                    default: begin
                    end
                endcase
            end

            // any older valid lsu blocks younger ones even when it issues
            if (valid_vec[i] && (woken[i].op_unit == issue_pkg::lsu)) begin
                older_lsu = 1'b1;
            end
        end
    end

    // k-th issued entry in age order goes to port k
    always_comb begin
        for (int k = 0; k < issue_pkg::OUT_PORTS; k++) begin
            issue_valid[k] = 1'b0;
            issue_data[k] = '0;
            for (int i = 0; i < issue_pkg::DEPTH; i++) begin
                if (issued_mask[i] && (slot[i] == issue_pkg::PORT_W'(k))) begin
                    issue_valid[k] = 1'b1;
                    issue_data[k] = woken[i];
                end
            end
        end
    end

endmodule

//--- iq_storage.sv
`timescale 1ns/1ps

module iq_storage (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic push,
    input issue_pkg::iq_entry_t dispatch_data [0:issue_pkg::IN_PORTS-1],
    input logic [issue_pkg::IN_PORTS-1:0] dispatch_valid,
    input issue_pkg::iq_entry_t woken [0:issue_pkg::DEPTH-1],
    input logic [issue_pkg::DEPTH-1:0] issued_mask,
    output issue_pkg::iq_entry_t entries [0:issue_pkg::DEPTH-1],
    output logic [issue_pkg::CNT_W-1:0] count,
    output logic [issue_pkg::IN_PORTS-1:0] channel_enable,
    output logic full,
    output logic empty
);

    logic [issue_pkg::CNT_W-1:0] free_space;
    logic [issue_pkg::IN_PORTS-1:0] accepted;
    logic [issue_pkg::CNT_W-1:0] issue_num;
    logic [issue_pkg::CNT_W-1:0] accept_num;
    logic [issue_pkg::CNT_W-1:0] count_next;

    // candidates for the next queue image, oldest first
    issue_pkg::iq_entry_t merged [0:issue_pkg::MERGE_NUM-1];
    logic [issue_pkg::MERGE_NUM-1:0] keep;
    logic [issue_pkg::CNT_W-1:0] dst [0:issue_pkg::MERGE_NUM-1];

    logic [issue_pkg::SRC_W-1:0] map_src [0:issue_pkg::DEPTH-1];
    logic [issue_pkg::DEPTH-1:0] map_valid;

    assign full = (count == issue_pkg::CNT_W'(issue_pkg::DEPTH));
    assign empty = (count == '0);
    assign free_space = issue_pkg::CNT_W'(issue_pkg::DEPTH) - count;

    // low min(free, IN_PORTS) channels open
    always_comb begin
        for (int k = 0; k < issue_pkg::IN_PORTS; k++) begin
            channel_enable[k] = free_space > issue_pkg::CNT_W'(k);
        end
    end

    assign accepted = {issue_pkg::IN_PORTS{push}} & dispatch_valid & channel_enable;

    assign issue_num = issue_pkg::CNT_W'(issue_pkg::count_ones(32'(issued_mask)));
    assign accept_num = issue_pkg::CNT_W'(issue_pkg::count_ones(32'(accepted)));
    assign count_next = count - issue_num + accept_num;

    always_comb begin
        for (int j = 0; j < issue_pkg::DEPTH; j++) begin
            merged[j] = woken[j];
            keep[j] = (issue_pkg::CNT_W'(j) < count) && !issued_mask[j];
        end
        // new entries go in as dispatched without same-cycle wakeup
        for (int k = 0; k < issue_pkg::IN_PORTS; k++) begin
            merged[issue_pkg::DEPTH + k] = dispatch_data[k];
            keep[issue_pkg::DEPTH + k] = accepted[k];
        end
    end

    // destination slot of each candidate is the number kept ahead of it
    always_comb begin
        dst[0] = '0;
        for (int j = 1; j < issue_pkg::MERGE_NUM; j++) begin
            dst[j] = dst[j-1] + issue_pkg::CNT_W'(keep[j-1]);
        end
    end

    // invert into a destination -> source map
    always_comb begin
        for (int d = 0; d < issue_pkg::DEPTH; d++) begin
            map_valid[d] = 1'b0;
            map_src[d] = '0;
            for (int j = issue_pkg::MERGE_NUM - 1; j >= 0; j--) begin
                if (keep[j] && (dst[j] == issue_pkg::CNT_W'(d))) begin
                    map_valid[d] = 1'b1;
                    map_src[d] = issue_pkg::SRC_W'(j);
                end
            end
        end
    end

    // slots past the new count keep stale data
    always_ff @(posedge clk) begin
        for (int d = 0; d < issue_pkg::DEPTH; d++) begin
            if (map_valid[d]) begin
                entries[d] <= merged[map_src[d]];
            end
        end
    end

    // flush wins over push
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

endmodule

//--- issue_queue.sv
`timescale 1ns/1ps

module issue_queue (
    input logic clk,
    input logic reset,
    input logic push,
    input logic flush,
    input issue_pkg::iq_entry_t dispatch_data [0:issue_pkg::IN_PORTS-1],
    input logic [issue_pkg::IN_PORTS-1:0] dispatch_valid,
    input issue_pkg::wb_feedback_t wb_feedback,
    input issue_pkg::unit_free_t unit_free,
    output logic [issue_pkg::IN_PORTS-1:0] channel_enable,
    output logic full,
    output logic empty,
    output issue_pkg::iq_entry_t issue_data [0:issue_pkg::OUT_PORTS-1],
    output logic [issue_pkg::OUT_PORTS-1:0] issue_valid
);

    issue_pkg::iq_entry_t entries [0:issue_pkg::DEPTH-1];
    issue_pkg::iq_entry_t woken [0:issue_pkg::DEPTH-1];
    logic [issue_pkg::CNT_W-1:0] count;
    logic [issue_pkg::DEPTH-1:0] issued_mask;

    // registered queue, insert and compaction
    iq_storage i_storage (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .push(push),
        .dispatch_data(dispatch_data),
        .dispatch_valid(dispatch_valid),
        .woken(woken),
        .issued_mask(issued_mask),
        .entries(entries),
        .count(count),
        .channel_enable(channel_enable),
        .full(full),
        .empty(empty)
    );

    // operand capture from the writeback bus
    iq_wakeup i_wakeup (
        .entries(entries),
        .wb_feedback(wb_feedback),
        .woken(woken)
    );

    // oldest-first pick onto the issue ports
    iq_select i_select (
        .woken(woken),
        .count(count),
        .unit_free(unit_free),
        .issued_mask(issued_mask),
        .issue_data(issue_data),
        .issue_valid(issue_valid)
    );

endmodule

//--- issue_queue_sva.sv
`timescale 1ns/1ps

module issue_queue_sva (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic full,
    input logic empty,
    input logic [issue_pkg::OUT_PORTS-1:0] issue_valid
);

    // number of failed assertions
    int assert_errors = 0;

    flags_exclusive: assert property (@(posedge clk) disable iff (reset) !(full && empty))
        else begin
            assert_errors++;
            $error("full and empty are high together");
        end

    // ports fill from 0 upward
    valid_contiguous: assert property (@(posedge clk) disable iff (reset)
        ((issue_valid & (issue_valid + 1'b1)) == '0))
        else begin
            assert_errors++;
            $error("issue_valid is not contiguous from port 0");
        end

    no_issue_when_empty: assert property (@(posedge clk) disable iff (reset)
        empty |-> (issue_valid == '0))
        else begin
            assert_errors++;
            $error("issue_valid set while the queue is empty");
        end

    flush_empties: assert property (@(posedge clk) disable iff (reset) flush |=> empty)
        else begin
            assert_errors++;
            $error("queue not empty in the cycle after flush");
        end

endmodule

//--- tb_issue_queue.sv
`timescale 1ns/1ps

module tb_issue_queue;

    typedef struct packed {
        logic push;
        logic flush;
        logic [issue_pkg::IN_PORTS-1:0] valid;
        issue_pkg::iq_entry_t [issue_pkg::IN_PORTS-1:0] data;
        issue_pkg::wb_feedback_t wb;
        issue_pkg::unit_free_t free;
    } stim_t;

    typedef struct packed {
        issue_pkg::iq_entry_t [issue_pkg::DEPTH-1:0] q;
        logic [issue_pkg::CNT_W-1:0] count;
    } model_t;

    typedef struct packed {
        logic [issue_pkg::IN_PORTS-1:0] chan_en;
        logic full;
        logic empty;
        logic [issue_pkg::OUT_PORTS-1:0] valid;
        issue_pkg::iq_entry_t [issue_pkg::OUT_PORTS-1:0] data;
    } expect_t;

    typedef struct packed {
        model_t next;
        expect_t exp;
    } step_t;

    logic clk = 1'b0;
    logic reset;
    logic push;
    logic flush;
    issue_pkg::iq_entry_t dispatch_data [0:issue_pkg::IN_PORTS-1];
    logic [issue_pkg::IN_PORTS-1:0] dispatch_valid;
    issue_pkg::wb_feedback_t wb_feedback;
    issue_pkg::unit_free_t unit_free;
    logic [issue_pkg::IN_PORTS-1:0] channel_enable;
    logic full;
    logic empty;
    issue_pkg::iq_entry_t issue_data [0:issue_pkg::OUT_PORTS-1];
    logic [issue_pkg::OUT_PORTS-1:0] issue_valid;

    stim_t cur;
    model_t model;
    step_t step;
    logic [31:0] lcg_state = 32'd5;
    logic [issue_pkg::ROB_W-1:0] rob_seq = '0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    issue_queue i_dut (
        .clk(clk),
        .reset(reset),
        .push(push),
        .flush(flush),
        .dispatch_data(dispatch_data),
        .dispatch_valid(dispatch_valid),
        .wb_feedback(wb_feedback),
        .unit_free(unit_free),
        .channel_enable(channel_enable),
        .full(full),
        .empty(empty),
        .issue_data(issue_data),
        .issue_valid(issue_valid)
    );

    bind issue_queue issue_queue_sva i_sva (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .full(full),
        .empty(empty),
        .issue_valid(issue_valid)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic stim_t quiet();
        stim_t s;
        s = '0;
        s.free = '1;
        return s;
    endfunction

    function automatic issue_pkg::iq_entry_t make_entry(
        input issue_pkg::op_unit_t op,
        input logic [issue_pkg::PHY_W-1:0] rs1,
        input logic ld1,
        input logic [issue_pkg::PHY_W-1:0] rs2,
        input logic ld2
    );
        issue_pkg::iq_entry_t e;
        e.rob_id = rob_seq;
        e.op_unit = op;
        e.rs1_phy = rs1;
        e.src1_loaded = ld1;
        e.src1_value = lcg_next();
        e.rs2_phy = rs2;
        e.src2_loaded = ld2;
        e.src2_value = lcg_next();
        e.rd_phy = issue_pkg::PHY_W'(lcg_next() >> 16);
        rob_seq = rob_seq + 1'b1;
        return e;
    endfunction

    function automatic issue_pkg::iq_entry_t random_entry();
        logic [31:0] r;
        issue_pkg::op_unit_t op;
        r = lcg_next();
        case (r[17:16])
            2'd1: op = issue_pkg::lsu;
            2'd2: op = issue_pkg::mul;
            default: op = issue_pkg::alu;
        endcase
        // small phy range so that feedback hits often
        return make_entry(op, {2'b00, r[21:18]}, r[22] | r[23], {2'b00, r[27:24]}, r[28] | r[29]);
    endfunction

    function automatic stim_t random_stim();
        stim_t s;
        logic [31:0] r;
        int n;
        s = quiet();
        r = lcg_next();
        s.push = r[16] | r[17];
        s.flush = (r[30:25] == 6'd0);
        n = int'(r[19:18]) % (issue_pkg::IN_PORTS + 1);
        s.valid = issue_pkg::IN_PORTS'((1 << n) - 1);
        s.free = r[20 +: $bits(issue_pkg::unit_free_t)];
        for (int k = 0; k < issue_pkg::IN_PORTS; k++) begin
            s.data[k] = random_entry();
        end
        for (int c = 0; c < issue_pkg::WB_CHANNELS; c++) begin
            r = lcg_next();
            s.wb[c].enable = r[16];
            s.wb[c].phy_id = {2'b00, r[20:17]};
            s.wb[c].value = lcg_next();
        end
        return s;
    endfunction

    function automatic int first_channel(input issue_pkg::wb_feedback_t fb,
                                         input logic [issue_pkg::PHY_W-1:0] phy);
        for (int c = 0; c < issue_pkg::WB_CHANNELS; c++) begin
            if (fb[c].enable && (fb[c].phy_id == phy)) begin
                return c;
            end
        end
        return -1;
    endfunction

    // one cycle of the queue: wakeup, select, insert, compaction
    function automatic step_t ref_step(input model_t m, input stim_t s);
        step_t r;
        issue_pkg::iq_entry_t [issue_pkg::DEPTH-1:0] w;
        logic [issue_pkg::DEPTH-1:0] issued;
        logic [issue_pkg::IN_PORTS-1:0] accepted;
        int budget [0:2];
        int ch;
        int ports;
        int fill;
        logic lsu_seen;
        logic go;
        r = '0;
        issued = '0;
        for (int i = 0; i < issue_pkg::DEPTH; i++) begin
            w[i] = m.q[i];
            ch = first_channel(s.wb, m.q[i].rs1_phy);
            if (!m.q[i].src1_loaded && ch >= 0) begin
                w[i].src1_loaded = 1'b1;
                w[i].src1_value = s.wb[ch].value;
            end
            ch = first_channel(s.wb, m.q[i].rs2_phy);
            if (!m.q[i].src2_loaded && ch >= 0) begin
                w[i].src2_loaded = 1'b1;
                w[i].src2_value = s.wb[ch].value;
            end
        end
        // budget index follows the enum encoding alu, lsu, mul
        budget[0] = $countones(s.free.alu);
        budget[1] = $countones(s.free.lsu);
        budget[2] = $countones(s.free.mul);
        ports = 0;
        lsu_seen = 1'b0;
        for (int i = 0; i < int'(m.count); i++) begin
            go = w[i].src1_loaded && w[i].src2_loaded && (ports < issue_pkg::OUT_PORTS)
                 && (budget[int'(w[i].op_unit)] > 0);
            if (w[i].op_unit == issue_pkg::lsu && lsu_seen) begin
                go = 1'b0;
            end
            if (go) begin
                issued[i] = 1'b1;
                r.exp.valid[ports] = 1'b1;
                r.exp.data[ports] = w[i];
                ports++;
                budget[int'(w[i].op_unit)]--;
            end
            if (w[i].op_unit == issue_pkg::lsu) begin
                lsu_seen = 1'b1;
            end
        end
        for (int k = 0; k < issue_pkg::IN_PORTS; k++) begin
            r.exp.chan_en[k] = k < (issue_pkg::DEPTH - int'(m.count));
            accepted[k] = s.push && s.valid[k] && r.exp.chan_en[k];
        end
        r.exp.full = (int'(m.count) == issue_pkg::DEPTH);
        r.exp.empty = (m.count == '0);
        fill = 0;
        for (int i = 0; i < int'(m.count); i++) begin
            if (!issued[i]) begin
                r.next.q[fill] = w[i];
                fill++;
            end
        end
        // new entries go in exactly as dispatched
        for (int k = 0; k < issue_pkg::IN_PORTS; k++) begin
            if (accepted[k]) begin
                r.next.q[fill] = s.data[k];
                fill++;
            end
        end
        r.next.count = s.flush ? '0 : issue_pkg::CNT_W'(fill);
        return r;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR time=%0t signal=%s expected=0x%0h actual=0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic apply(input stim_t s);
        cur = s;
        push = s.push;
        flush = s.flush;
        dispatch_valid = s.valid;
        for (int k = 0; k < issue_pkg::IN_PORTS; k++) begin
            dispatch_data[k] = s.data[k];
        end
        wb_feedback = s.wb;
        unit_free = s.free;
    endtask

    task automatic drive(input stim_t s);
        @(negedge clk);
        apply(s);
    endtask

    task automatic idle(input int n, input issue_pkg::unit_free_t free);
        stim_t s;
        s = quiet();
        s.free = free;
        repeat (n) drive(s);
    endtask

    task automatic push_two(input issue_pkg::iq_entry_t e0, input issue_pkg::iq_entry_t e1,
                            input logic [issue_pkg::IN_PORTS-1:0] valid,
                            input issue_pkg::unit_free_t free);
        stim_t s;
        s = quiet();
        s.push = 1'b1;
        s.valid = valid;
        s.data[0] = e0;
        s.data[1] = e1;
        s.free = free;
        drive(s);
    endtask

    task automatic directed_tests();
        stim_t s;
        issue_pkg::unit_free_t none;
        issue_pkg::unit_free_t one_alu;
        none = '0;
        one_alu = '0;
        one_alu.alu = 2'b01;
        one_alu.mul = 1'b1;
        // every ready alu pair issues the cycle after its push
        repeat (4) push_two(make_entry(issue_pkg::alu, 6'd1, 1'b1, 6'd2, 1'b1),
                            make_entry(issue_pkg::alu, 6'd3, 1'b1, 6'd4, 1'b1), 2'b11, '1);
        idle(3, '1);
        // wakeup with phy 10 on channels 1 and 2
        push_two(make_entry(issue_pkg::alu, 6'd10, 1'b0, 6'd3, 1'b1),
                 make_entry(issue_pkg::alu, 6'd4, 1'b1, 6'd11, 1'b0), 2'b11, '1);
        idle(3, '1);
        s = quiet();
        s.wb[0] = {1'b1, 6'd11, 32'h1111_0000};
        s.wb[1] = {1'b1, 6'd10, 32'h2222_0000};
        s.wb[2] = {1'b1, 6'd10, 32'h3333_0000};
        drive(s);
        idle(2, '1);
        // with one alu free the mul behind two alus takes the second port
        push_two(make_entry(issue_pkg::alu, 6'd1, 1'b1, 6'd2, 1'b1),
                 make_entry(issue_pkg::alu, 6'd3, 1'b1, 6'd4, 1'b1), 2'b11, none);
        push_two(make_entry(issue_pkg::mul, 6'd5, 1'b1, 6'd6, 1'b1), '0, 2'b01, none);
        idle(4, one_alu);
        // younger ready lsu waits for the older one
        push_two(make_entry(issue_pkg::lsu, 6'd20, 1'b0, 6'd5, 1'b1),
                 make_entry(issue_pkg::lsu, 6'd6, 1'b1, 6'd7, 1'b1), 2'b11, '1);
        idle(3, '1);
        s = quiet();
        s.wb[2] = {1'b1, 6'd20, 32'h4444_0000};
        drive(s);
        idle(3, '1);
        // fill to 1, 3, 5, 7, 8, then overflow and flush
        push_two(make_entry(issue_pkg::alu, 6'd1, 1'b1, 6'd2, 1'b1), '0, 2'b01, none);
        repeat (5) push_two(make_entry(issue_pkg::alu, 6'd1, 1'b1, 6'd2, 1'b1),
                            make_entry(issue_pkg::mul, 6'd3, 1'b1, 6'd4, 1'b1), 2'b11, none);
        s = quiet();
        s.free = none;
        s.flush = 1'b1;
        s.push = 1'b1;
        s.valid = 2'b11;
        s.data[0] = make_entry(issue_pkg::alu, 6'd1, 1'b1, 6'd2, 1'b1);
        drive(s);
        // flush also wins over a push that has room
        s.free = '1;
        drive(s);
        idle(3, '1);
    endtask

    // compare just before each rising edge, then advance the model
    always @(negedge clk) begin
        #15;
        if (reset) begin
            model.count = '0;
        end else begin
            step = ref_step(model, cur);
            check_value("channel_enable", step.exp.chan_en, channel_enable);
            check_value("full", step.exp.full, full);
            check_value("empty", step.exp.empty, empty);
            check_value("issue_valid", step.exp.valid, issue_valid);
            for (int k = 0; k < issue_pkg::OUT_PORTS; k++) begin
                if (step.exp.valid[k]) begin
                    check_value($sformatf("issue_data[%0d]", k), step.exp.data[k],
                                issue_data[k]);
                end
            end
            model = step.next;
        end
    end

    // limit is about five times the length of all tests
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 2000) begin
            $display("timeout: the run did not finish within %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        model = '0;
        apply(quiet());
        repeat (5) @(negedge clk);
        reset = 1'b0;
        directed_tests();
        repeat (300) drive(random_stim());
        idle(4, '1);
        @(negedge clk);
        $display("checks: %0d, value errors: %0d, assertion errors: %0d",
                 checks, errors, i_dut.i_sva.assert_errors);
        if (errors == 0 && i_dut.i_sva.assert_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- compile.f
issue_pkg.sv
iq_wakeup.sv
iq_select.sv
iq_storage.sv
issue_queue.sv
issue_queue_sva.sv
tb_issue_queue.sv
